//--- hdl/frame_pkg.sv
package frame_pkg;

    // one octet on the air and in the buffer
    typedef logic [7:0] byte_t;

    // frame type byte, third octet of every frame
    typedef enum logic [7:0] {
        data_plain   = 8'd0,
        data_checked = 8'd1,
        data_ack_req = 8'd2,
        ack          = 8'd3
    } frame_type_e;

    // destination accepted by every station
    localparam byte_t BROADCAST_ADDR = 8'h2A;

    // field positions counted from the destination byte
    localparam int DEST_OFFSET = 0;
    localparam int SRC_OFFSET  = 1;
    localparam int TYPE_OFFSET = 2;

    // dest, source, type and fcs with an empty payload
    localparam int MIN_FRAME_LEN = 4;

    // crc-8, x^8 + x^2 + x + 1, zero init, msb first
    localparam byte_t CRC_POLY = 8'h07;
    localparam byte_t CRC_INIT = 8'h00;

endpackage

//--- hdl/rcv_pkg.sv
package rcv_pkg;

    import frame_pkg::*;

    // frame store size
    localparam int BUF_DEPTH  = 512;
    localparam int BUF_ADDR_W = 9;

    typedef logic [BUF_ADDR_W-1:0] buf_addr_t;

    // byte receiver output, valid is a one-cycle strobe
    typedef struct packed {
        logic  cardet;
        logic  valid;
        byte_t data;
    } rx_in_t;

    typedef struct packed {
        logic      en;
        buf_addr_t addr;
        byte_t     data;
    } buf_wr_t;

    typedef struct packed {
        logic      en;
        buf_addr_t addr;
    } buf_rd_t;

    // delivery stream toward the uart
    typedef struct packed {
        logic  rvalid;
        byte_t rdata;
    } rd_out_t;

    typedef enum logic [2:0] {
        idle,
        store,
        fetch_type,
        decide,
        fetch_byte,
        present
    } rcv_state_e;

endpackage

//--- hdl/frame_buffer.sv
`timescale 1ns/1ps

module frame_buffer
    import frame_pkg::*;
    import rcv_pkg::*;
(
    input  logic    clk,
    input  buf_wr_t wr,
    input  buf_rd_t rd,
    output byte_t   rd_data
);

    byte_t mem [BUF_DEPTH];

    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // registered read port holds its output between reads
    always_ff @(posedge clk) begin
        if (rd.en) begin
            rd_data <= mem[rd.addr];
        end
    end

    // a read in the same cycle as a write to that address returns stale data
    a_no_rw_collision : assert property (
        @(posedge clk) !(wr.en && rd.en && (wr.addr == rd.addr))
    ) else $error("frame_buffer: read and write to address %0d together", wr.addr);

endmodule

//--- hdl/fcs_checker.sv
`timescale 1ns/1ps

module fcs_checker
    import frame_pkg::*;
    import rcv_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    clear,
    input  buf_wr_t wr,
    output logic    fcs_ok
);

    byte_t crc_q;

    // one byte through the crc, msb first
    function automatic byte_t crc8_byte(input byte_t crc, input byte_t data);
        byte_t c;
        c = crc ^ data;
        for (int i = 0; i < 8; i++) begin
            if (c[7]) begin
                c = (c << 1) ^ CRC_POLY;
            end else begin
                c = c << 1;
            end
        end
        return c;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            crc_q <= CRC_INIT;
        end else if (clear) begin
            crc_q <= CRC_INIT;
        end else if (wr.en) begin
            crc_q <= crc8_byte(crc_q, wr.data);
        end
    end

    // residue over data plus fcs is zero on a good frame
    assign fcs_ok = (crc_q == 8'h00);

    // the controller must never clear on a cycle that stores a byte
    a_no_clear_on_write : assert property (
        @(posedge clk) disable iff (rst) !(clear && wr.en)
    ) else $error("fcs_checker: clear during write");

endmodule

//--- hdl/rcv_controller.sv
`timescale 1ns/1ps

module rcv_controller
    import frame_pkg::*;
    import rcv_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  byte_t   mac_addr,
    input  rx_in_t  rx,
    input  logic    rrdy,
    input  byte_t   rd_data,
    input  logic    fcs_ok,
    output buf_wr_t wr,
    output buf_rd_t rd,
    output logic    crc_clear,
    output rd_out_t rd_out,
    output logic    ack_needed,
    output logic    ack_received,
    output byte_t   rerrcount
);

    rcv_state_e state, state_nxt;

    buf_addr_t         wr_addr;
    buf_addr_t         rd_addr;
    logic [BUF_ADDR_W:0] frame_len;
    logic [BUF_ADDR_W:0] last_idx;
    byte_t             dest_q;
    logic              overflow;
    logic              mid_frame;

    logic        rx_byte;
    logic        addr_match;
    logic        accept;
    logic        store_byte;
    logic        frame_short;
    logic        err_step;
    logic        deliver;
    frame_type_e frame_type;

    always_comb begin
        rx_byte    = rx.valid && rx.cardet;
        addr_match = (rx.data == mac_addr) || (rx.data == BROADCAST_ADDR);
        // only the first byte after carrier rises is an address
        accept     = (state == idle) && rx_byte && !mid_frame && addr_match;
        store_byte = (state == store) && rx_byte && (frame_len < BUF_DEPTH);
        last_idx   = frame_len - 1'b1;
        frame_type = frame_type_e'(rd_data);
        frame_short = (frame_len < MIN_FRAME_LEN) || overflow;
    end

    // buffer and crc side
    always_comb begin
        wr.en   = accept || store_byte;
        wr.addr = accept ? '0 : wr_addr;
        wr.data = rx.data;

        rd.en   = (state == fetch_type) || (state == fetch_byte);
        rd.addr = (state == fetch_type) ? buf_addr_t'(TYPE_OFFSET) : rd_addr;

        // decide also clears so a frame right after it starts from zero
        crc_clear = ((state == idle) && !accept) || (state == decide);
    end

    // rd_data holds the type byte during decide
    always_comb begin
        err_step     = 1'b0;
        deliver      = 1'b0;
        ack_needed   = 1'b0;
        ack_received = 1'b0;
        if (state == decide) begin
            if (frame_short) begin
                err_step = 1'b1;
            end else begin
                case (frame_type)
                    data_plain: begin
                        deliver = 1'b1;
                    end
                    data_checked: begin
                        deliver  = fcs_ok;
                        err_step = !fcs_ok;
                    end
                    data_ack_req: begin
                        deliver  = fcs_ok;
                        err_step = !fcs_ok;
                        // no ack for broadcast copies
                        ack_needed = fcs_ok && (dest_q == mac_addr)
                                     && (dest_q != BROADCAST_ADDR);
                    end
                    ack: begin
                        ack_received = fcs_ok;
                        err_step     = !fcs_ok;
                    end
                    default: begin
                        // unknown types are dropped quietly
                    end
                endcase
            end
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            idle: begin
                if (accept) begin
                    state_nxt = store;
                end
            end
            store: begin
                if (!rx.cardet) begin
                    state_nxt = fetch_type;
                end
            end
            fetch_type: begin
                state_nxt = decide;
            end
            decide: begin
                state_nxt = deliver ? fetch_byte : idle;
            end
            fetch_byte: begin
                state_nxt = present;
            end
            present: begin
                // fcs byte at last_idx is never sent
                if (rrdy) begin
                    if ({1'b0, rd_addr} == last_idx) begin
                        state_nxt = idle;
                    end else begin
                        state_nxt = fetch_byte;
                    end
                end
            end
            default: begin
                state_nxt = idle;
            end
        endcase
    end

    assign rd_out.rvalid = (state == present);
    assign rd_out.rdata  = rd_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= idle;
            wr_addr   <= '0;
            rd_addr   <= '0;
            frame_len <= '0;
            overflow  <= 1'b0;
            mid_frame <= 1'b0;
            rerrcount <= '0;
        end else begin
            state <= state_nxt;

            if (!rx.cardet) begin
                mid_frame <= 1'b0;
            end else if (rx.valid) begin
                mid_frame <= 1'b1;
            end

            if (accept) begin
                wr_addr   <= buf_addr_t'(1);
                frame_len <= 1'b1;
                overflow  <= 1'b0;
            end else if (store_byte) begin
                wr_addr   <= wr_addr + 1'b1;
                frame_len <= frame_len + 1'b1;
            end

            // remaining bytes are lost once the buffer is full
            if ((state == store) && rx_byte && (frame_len == BUF_DEPTH)) begin
                overflow <= 1'b1;
            end

            if (state == decide) begin
                rd_addr <= '0;
            end else if (state == fetch_byte) begin
                rd_addr <= rd_addr + 1'b1;
            end

            if (err_step && (rerrcount != 8'hFF)) begin
                rerrcount <= rerrcount + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            dest_q <= rx.data;
        end
    end

    // a presented byte stays until the sink takes it
    a_rvalid_held : assert property (
        @(posedge clk) disable iff (rst)
        rd_out.rvalid && !rrdy |=> rd_out.rvalid
    ) else $error("rcv_controller: rvalid dropped before handshake");

    a_rdata_stable : assert property (
        @(posedge clk) disable iff (rst)
        rd_out.rvalid && !rrdy |=> $stable(rd_out.rdata)
    ) else $error("rcv_controller: rdata changed under back-pressure");

    // delivery never fetches the fcs byte or anything past it
    a_fetch_in_frame : assert property (
        @(posedge clk) disable iff (rst)
        (state == fetch_byte) |-> ({1'b0, rd_addr} < last_idx)
    ) else $error("rcv_controller: fetch beyond the last payload byte");

endmodule

//--- hdl/rcv_top.sv
`timescale 1ns/1ps

module rcv_top
    import frame_pkg::*;
    import rcv_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  byte_t   mac_addr,
    input  rx_in_t  rx,
    input  logic    rrdy,
    output rd_out_t rd_out,
    output logic    ack_needed,
    output logic    ack_received,
    output byte_t   rerrcount
);

    buf_wr_t buf_wr;
    buf_rd_t buf_rd;
    byte_t   buf_rd_data;
    logic    crc_clear;
    logic    fcs_ok;

    rcv_controller ctrl_i (
        .clk          (clk),
        .rst          (rst),
        .mac_addr     (mac_addr),
        .rx           (rx),
        .rrdy         (rrdy),
        .rd_data      (buf_rd_data),
        .fcs_ok       (fcs_ok),
        .wr           (buf_wr),
        .rd           (buf_rd),
        .crc_clear    (crc_clear),
        .rd_out       (rd_out),
        .ack_needed   (ack_needed),
        .ack_received (ack_received),
        .rerrcount    (rerrcount)
    );

    frame_buffer buf_i (
        .clk     (clk),
        .wr      (buf_wr),
        .rd      (buf_rd),
        .rd_data (buf_rd_data)
    );

    // sees the same writes as the buffer
    fcs_checker fcs_i (
        .clk    (clk),
        .rst    (rst),
        .clear  (crc_clear),
        .wr     (buf_wr),
        .fcs_ok (fcs_ok)
    );

endmodule

//--- verification/rcv_tb.sv
`timescale 1ns/1ps

module rcv_tb
    import frame_pkg::*;
    import rcv_pkg::*;
;

    localparam byte_t MAC_ADDR      = 8'h5C;
    localparam byte_t OTHER_ADDR    = 8'h77;
    localparam int    DRAIN_TIMEOUT = 2000;

    logic    clk;
    logic    rst;
    byte_t   mac_addr;
    rx_in_t  rx;
    logic    rrdy;
    rd_out_t rd_out;
    logic    ack_needed;
    logic    ack_received;
    byte_t   rerrcount;

    // reference model state
    byte_t frame_q[$];
    byte_t exp_q[$];
    byte_t exp_head;
    int    exp_count;
    int    exp_errs;
    int    exp_ack_needed;
    int    exp_ack_received;
    int    seen_ack_needed;
    int    seen_ack_received;

    string test_name;
    int    test_errs;
    int    total_errs;
    int    n_tests;
    int    n_failed;

    rcv_top dut_i (
        .clk          (clk),
        .rst          (rst),
        .mac_addr     (mac_addr),
        .rx           (rx),
        .rrdy         (rrdy),
        .rd_out       (rd_out),
        .ack_needed   (ack_needed),
        .ack_received (ack_received),
        .rerrcount    (rerrcount)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // sink ready about three cycles in four
    task automatic drive_ready();
        forever begin
            @(posedge clk);
            if (rst) begin
                rrdy <= 1'b0;
            end else begin
                rrdy <= ($urandom % 4) != 0;
            end
        end
    endtask

    // head and count lag the queue by one edge
    always @(posedge clk) begin
        if (rd_out.rvalid && rrdy && exp_q.size() != 0) begin
            void'(exp_q.pop_front());
        end
        exp_count <= exp_q.size();
        exp_head  <= (exp_q.size() != 0) ? exp_q[0] : 8'h00;
        if (!rst && ack_needed) begin
            seen_ack_needed++;
        end
        if (!rst && ack_received) begin
            seen_ack_received++;
        end
    end

    a_stream_data : assert property (
        @(posedge clk) disable iff (rst)
        rd_out.rvalid && rrdy && exp_count != 0 |-> rd_out.rdata == exp_head
    ) else begin
        test_errs++;
        $display("FAIL %s: delivered byte expected %02h got %02h",
                 test_name, $sampled(exp_head), $sampled(rd_out.rdata));
    end

    a_no_extra_byte : assert property (
        @(posedge clk) disable iff (rst)
        rd_out.rvalid |-> exp_count != 0
    ) else begin
        test_errs++;
        $display("test %s: a byte was presented when none was expected", test_name);
    end

    // pulses come 2 clocks after carrier is first seen low
    a_decide_timing : assert property (
        @(posedge clk) disable iff (rst)
        (ack_needed || ack_received) |-> !$past(rx.cardet, 2) && $past(rx.cardet, 3)
    ) else begin
        test_errs++;
        $display("test %s: ack pulse not 2 cycles after carrier drop", test_name);
    end

    // bitwise msb-first crc-8
    function automatic byte_t crc8_step(input byte_t crc, input byte_t d);
        byte_t r;
        logic  fb;
        r = crc;
        for (int i = 7; i >= 0; i--) begin
            fb = r[7] ^ d[i];
            r  = {r[6:0], 1'b0};
            if (fb) begin
                r = r ^ CRC_POLY;
            end
        end
        return r;
    endfunction

    task automatic count_error();
        if (exp_errs != 255) begin
            exp_errs++;
        end
    endtask

    // what the receiver should do with frame_q
    task automatic predict_frame();
        int    len;
        byte_t crc;
        logic  good;
        len = frame_q.size();
        if (len == 0) begin
            return;
        end
        if (frame_q[0] != MAC_ADDR && frame_q[0] != BROADCAST_ADDR) begin
            return;
        end
        if (len < MIN_FRAME_LEN) begin
            count_error();
            return;
        end
        crc = 8'h00;
        for (int i = 0; i < len - 1; i++) begin
            crc = crc8_step(crc, frame_q[i]);
        end
        good = (crc == frame_q[len-1]);
        case (frame_type_e'(frame_q[TYPE_OFFSET]))
            data_plain, data_checked, data_ack_req: begin
                if (good || frame_q[TYPE_OFFSET] == data_plain) begin
                    for (int i = 0; i < len - 1; i++) begin
                        exp_q.push_back(frame_q[i]);
                    end
                    if (frame_q[TYPE_OFFSET] == data_ack_req && frame_q[0] == MAC_ADDR) begin
                        exp_ack_needed++;
                    end
                end else begin
                    count_error();
                end
            end
            ack: begin
                if (good) begin
                    exp_ack_received++;
                end else begin
                    count_error();
                end
            end
            default: begin
            end
        endcase
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while ((exp_q.size() != 0 || rd_out.rvalid) && cycles < DRAIN_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_q.size() != 0 || rd_out.rvalid) begin
            test_errs++;
            $display("test %s: timed out waiting for the frame to be delivered", test_name);
            exp_q.delete();
        end
    endtask

    // cut > 0 truncates the frame to that many bytes
    task automatic send_frame(input byte_t dest, input byte_t ftype, input int plen,
                              input bit corrupt, input int cut);
        byte_t crc;
        int    gap;
        frame_q.delete();
        frame_q.push_back(dest);
        frame_q.push_back(byte_t'($urandom));
        frame_q.push_back(ftype);
        for (int i = 0; i < plen; i++) begin
            frame_q.push_back(byte_t'($urandom));
        end
        crc = 8'h00;
        foreach (frame_q[i]) begin
            crc = crc8_step(crc, frame_q[i]);
        end
        frame_q.push_back(corrupt ? (crc ^ 8'h5A) : crc);
        while (cut > 0 && frame_q.size() > cut) begin
            void'(frame_q.pop_back());
        end
        predict_frame();
        @(posedge clk);
        rx.cardet <= 1'b1;
        foreach (frame_q[i]) begin
            @(posedge clk);
            rx.valid <= 1'b1;
            rx.data  <= frame_q[i];
            @(posedge clk);
            rx.valid <= 1'b0;
            gap = $urandom % 3;
            repeat (gap) @(posedge clk);
        end
        rx.cardet <= 1'b0;
        // the counter settles one clock after decide
        repeat (4) @(posedge clk);
        wait_drain();
        gap = 2 + $urandom % 4;
        repeat (gap) @(posedge clk);
    endtask

    task automatic check_value(input string what, input int expected, input int actual);
        assert (actual == expected) else begin
            test_errs++;
            $display("FAIL %s: %s expected %0d got %0d", test_name, what, expected, actual);
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        check_value("rerrcount", exp_errs, rerrcount);
        check_value("ack_needed pulses", exp_ack_needed, seen_ack_needed);
        check_value("ack_received pulses", exp_ack_received, seen_ack_received);
        total_errs += test_errs;
        n_tests++;
        if (test_errs == 0) begin
            $display("test %s: ok", test_name);
        end else begin
            n_failed++;
            $display("test %s: %0d errors", test_name, test_errs);
        end
    endtask

    initial begin
        void'($urandom(26910));
        rst               = 1'b1;
        mac_addr          = MAC_ADDR;
        rx                = '0;
        rrdy              = 1'b0;
        exp_errs          = 0;
        exp_ack_needed    = 0;
        exp_ack_received  = 0;
        seen_ack_needed   = 0;
        seen_ack_received = 0;
        total_errs        = 0;
        n_tests           = 0;
        n_failed          = 0;
        test_name         = "reset";
        test_errs         = 0;
        fork
            drive_ready();
        join_none
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        repeat (2) @(posedge clk);

        begin_test("good_checked_frame");
        send_frame(MAC_ADDR, data_checked, 12, 1'b0, 0);
        end_test();

        begin_test("other_address");
        send_frame(OTHER_ADDR, data_checked, 6, 1'b0, 0);
        end_test();

        begin_test("bad_fcs_and_short");
        send_frame(MAC_ADDR, data_checked, 5, 1'b1, 0);
        send_frame(MAC_ADDR, data_checked, 0, 1'b0, 3);
        end_test();

        begin_test("ack_request");
        send_frame(MAC_ADDR, data_ack_req, 7, 1'b0, 0);
        send_frame(BROADCAST_ADDR, data_ack_req, 7, 1'b0, 0);
        end_test();

        begin_test("ack_frames");
        send_frame(MAC_ADDR, ack, 0, 1'b0, 0);
        send_frame(MAC_ADDR, ack, 0, 1'b1, 0);
        end_test();

        begin_test("plain_bad_fcs");
        send_frame(MAC_ADDR, data_plain, 8, 1'b1, 0);
        end_test();

        $display("tests %0d, failed %0d, errors %0d", n_tests, n_failed, total_errs);
        if (total_errs == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- files.f
hdl/frame_pkg.sv
hdl/rcv_pkg.sv
hdl/frame_buffer.sv
hdl/fcs_checker.sv
hdl/rcv_controller.sv
hdl/rcv_top.sv
verification/rcv_tb.sv

//--- Bender.yml
package:
  name: rcv_mac

sources:
  # packages first, then leaf modules, then the top
  - files:
      - hdl/frame_pkg.sv
      - hdl/rcv_pkg.sv
      - hdl/frame_buffer.sv
      - hdl/fcs_checker.sv
      - hdl/rcv_controller.sv
      - hdl/rcv_top.sv
  - target: simulation
    files:
      - verification/rcv_tb.sv
